/* common/nic100_cfg.svh */
`ifndef NIC100_CFG_SVH
`define NIC100_CFG_SVH

// SPI opcodes
`define NIC_WCRU        8'h22  // Write control register, unbanked
`define NIC_RCRU        8'h20  // Read control register, unbanked
`define NIC_BFSU        8'h24  // Bit field set, unbanked
`define NIC_WUDADATA    8'h32
`define NIC_SETTXRTS    8'hD4
`define NIC_SETPKTDEC   8'hCC
`define NIC_WRXRDPT     8'h64
`define NIC_RRXDATA     8'h2C

// Register addresses, 8-bit SFR map
`define NIC_EUDASTL     8'h16
`define NIC_ESTATH      8'h1B
`define NIC_ECON1L      8'h1E
`define NIC_ETXSTL      8'h00  // Followed by ETXLEN
`define NIC_EUDAWRPTL   8'h90
`define NIC_ERXSTL      8'h04  // Followed by ERXTAIL
`define NIC_ERXTAILL    8'h06
`define NIC_PKTCNT      8'h1A  // Low byte of ESTAT

// Bit masks
`define NIC_CLKRDY      8'h10  // ESTATH
`define NIC_RXEN        8'h01  // ECON1L

// Receive buffer layout
`define NIC_RX_START      16'h3000
`define NIC_RX_TAIL_INIT  16'h5FFE

// 1234h as written, seen low byte first on readback
`define NIC_EUDAST_PATTERN  16'h3412

// Receive status vector handling
`define NIC_RSV_SKIP    4
`define NIC_CRC_BYTES   4

`endif

/* common/nic100_pkg.sv */
package nic100_pkg;

	typedef enum logic [1:0] {
		ph_none,
		ph_stream_wr,  // Bytes from wr_stream after the header
		ph_stream_rd   // Bytes to rd_stream until halted
	} spi_phase_e;

	// One SPI transaction for the executor
	typedef struct packed {
		logic [7:0]  opcode;
		logic        has_addr;
		logic [7:0]  addr;
		logic [2:0]  wr_count;  // Immediate bytes, 0 to 4
		logic [31:0] wr_word;   // Low byte goes first
		logic [1:0]  rd_count;  // Counted read bytes, 0 to 2
		spi_phase_e  phase;
	} spi_cmd_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       last;
	} stream_byte_t;

	typedef struct packed {
		logic       wr_valid;
		logic [7:0] wr_data;
	} spi_wr_t;

endpackage

/* hw/nic100_spi_cmd.sv */
`timescale 1ns/1ps

module nic100_spi_cmd import nic100_pkg::*; (
	input  logic         AXIS_ACLK,
	input  logic         AXIS_ARESETN,
	input  spi_cmd_t     cmd,
	input  logic         cmd_start,
	input  stream_byte_t wr_stream,
	input  logic         rd_halt,
	input  logic         wr_got_byte,
	input  logic         wr_done,
	input  logic         rd_valid,
	input  logic [7:0]   rd_data,
	output spi_wr_t      spi_wr,
	output logic         rd_stop,
	output logic         cmd_done,
	output logic [15:0]  rd_word,
	output logic         wr_take,
	output stream_byte_t rd_stream
);

	typedef enum logic [2:0] {
		S_IDLE, S_OPC, S_HDR, S_STRW, S_WDONE, S_RD, S_STRD
	} state_e;

	state_e      state;
	spi_cmd_t    cmd_q;
	logic [31:0] imm_sh;    // Next immediate byte sits in [7:0]
	logic [2:0]  imm_left;
	logic [1:0]  rd_left;
	logic        wr_valid_q;
	logic [7:0]  wr_data_q;
	logic        cur_last;  // Byte on wr_data closes the stream

	assign spi_wr.wr_valid = wr_valid_q;
	assign spi_wr.wr_data  = wr_data_q;
	assign wr_take = (state == S_STRW) && wr_got_byte;

	// Received bytes passed straight through
	assign rd_stream.valid = (state == S_STRD) && rd_valid;
	assign rd_stream.data  = rd_data;
	assign rd_stream.last  = 1'b0;  // consumer decides the end

	always_ff @(posedge AXIS_ACLK) begin
		if (!AXIS_ARESETN) begin
			state      <= S_IDLE;
			wr_valid_q <= 1'b0;
			rd_stop    <= 1'b1;
			cmd_done   <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmd_start) begin
						cmd_q      <= cmd;
						imm_sh     <= cmd.wr_word;
						imm_left   <= cmd.wr_count;
						rd_left    <= cmd.rd_count;
						wr_valid_q <= 1'b1;
						wr_data_q  <= cmd.opcode;
						state      <= S_OPC;
					end
				end
				S_OPC, S_HDR: begin
					if (wr_got_byte) begin
						if (state == S_OPC && cmd_q.has_addr) begin
							wr_data_q <= cmd_q.addr;
							state     <= S_HDR;
						end else if (imm_left != 3'd0) begin
							wr_data_q <= imm_sh[7:0];
							imm_sh    <= imm_sh >> 8;
							imm_left  <= imm_left - 3'd1;
							state     <= S_HDR;
						end else if (cmd_q.phase == ph_stream_wr) begin
							wr_data_q <= wr_stream.data;
							cur_last  <= wr_stream.last;
							state     <= S_STRW;
						end else begin
							// Header is out, hand the bus to the read side or finish
							wr_valid_q <= 1'b0;
							if (cmd_q.phase == ph_stream_rd) begin
								rd_stop <= 1'b0;
								state   <= S_STRD;
							end else if (cmd_q.rd_count != 2'd0) begin
								rd_stop <= 1'b0;
								state   <= S_RD;
							end else begin
								state <= S_WDONE;
							end
						end
					end
				end
				S_STRW: begin
					if (wr_got_byte) begin
						if (cur_last) begin
							wr_valid_q <= 1'b0;
							state      <= S_WDONE;
						end
					end else if (wr_stream.valid) begin
						wr_data_q <= wr_stream.data;  // Follow the next beat
						cur_last  <= wr_stream.last;
					end
				end
				S_WDONE: begin
					if (wr_done) begin
						cmd_done <= 1'b1;
						state    <= S_IDLE;
					end
				end
				S_RD: begin
					if (rd_valid) begin
						if (rd_left == cmd_q.rd_count)
							rd_word <= {8'h00, rd_data};  // First byte is low
						else
							rd_word[15:8] <= rd_data;
						rd_left <= rd_left - 2'd1;
						if (rd_left == 2'd1) begin
							rd_stop  <= 1'b1;
							cmd_done <= 1'b1;
							state    <= S_IDLE;
						end
					end
				end
				S_STRD: begin
					if (rd_halt) begin
						rd_stop  <= 1'b1;
						cmd_done <= 1'b1;
						state    <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* hw/nic100_init_seq.sv */
`timescale 1ns/1ps
`include "nic100_cfg.svh"

module nic100_init_seq import nic100_pkg::*; (
	input  logic        AXIS_ACLK,
	input  logic        AXIS_ARESETN,
	input  logic        cmd_done,
	input  logic [15:0] rd_word,
	output spi_cmd_t    cmd,
	output logic        cmd_start,
	output logic        init_done
);

	typedef enum logic [2:0] {
		I_EUDA_WR, I_EUDA_RD, I_CLKRDY, I_RXBUF, I_RXEN, I_DONE
	} state_e;

	state_e state;

	assign init_done = (state == I_DONE);

	always_comb begin
		cmd = '0;
		case (state)
			I_EUDA_WR: begin
				cmd.opcode   = `NIC_WCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_EUDASTL;
				cmd.wr_count = 3'd2;
				cmd.wr_word  = {16'h0000, `NIC_EUDAST_PATTERN};
			end
			I_EUDA_RD: begin
				cmd.opcode   = `NIC_RCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_EUDASTL;
				cmd.rd_count = 2'd2;
			end
			I_CLKRDY: begin
				cmd.opcode   = `NIC_RCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_ESTATH;
				cmd.rd_count = 2'd1;
			end
			I_RXBUF: begin  // ERXST then ERXTAIL
				cmd.opcode   = `NIC_WCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_ERXSTL;
				cmd.wr_count = 3'd4;
				cmd.wr_word  = {`NIC_RX_TAIL_INIT, `NIC_RX_START};
			end
			I_RXEN: begin
				cmd.opcode   = `NIC_BFSU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_ECON1L;
				cmd.wr_count = 3'd1;
				cmd.wr_word  = {24'h000000, `NIC_RXEN};
			end
			default: ;
		endcase
	end

	always_ff @(posedge AXIS_ACLK) begin
		if (!AXIS_ARESETN) begin
			state     <= I_EUDA_WR;
			cmd_start <= 1'b1;  // EUDAST write leaves as soon as reset lifts
		end else begin
			cmd_start <= 1'b0;
			if (cmd_done) begin
				case (state)
					I_EUDA_WR: begin
						state     <= I_EUDA_RD;
						cmd_start <= 1'b1;
					end
					I_EUDA_RD: begin
						// Interface not up yet if the pattern did not stick
						state     <= (rd_word == `NIC_EUDAST_PATTERN) ? I_CLKRDY : I_EUDA_WR;
						cmd_start <= 1'b1;
					end
					I_CLKRDY: begin
						if ((rd_word[7:0] & `NIC_CLKRDY) != 8'h00)
							state <= I_RXBUF;
						cmd_start <= 1'b1;
					end
					I_RXBUF: begin
						state     <= I_RXEN;
						cmd_start <= 1'b1;
					end
					I_RXEN: state <= I_DONE;
					default: ;
				endcase
			end
		end
	end

endmodule

/* hw/nic100_tx_seq.sv */
`timescale 1ns/1ps
`include "nic100_cfg.svh"

module nic100_tx_seq import nic100_pkg::*; (
	input  logic         AXIS_ACLK,
	input  logic         AXIS_ARESETN,
	input  logic         start,
	input  logic         cmd_done,
	input  logic [7:0]   s_tdata,
	input  logic         s_tvalid,
	input  logic         s_tlast,
	input  logic         wr_take,
	output spi_cmd_t     cmd,
	output logic         cmd_start,
	output stream_byte_t wr_stream,
	output logic         s_tready,
	output logic         busy
);

	typedef enum logic [2:0] {T_IDLE, T_WRPTR, T_DATA, T_LEN, T_RTS} state_e;

	state_e      state;
	logic [15:0] pkt_len;

	assign busy = (state != T_IDLE);

	// Beat is masked while its handshake completes
	assign wr_stream.valid = (state == T_DATA) && s_tvalid && !s_tready;
	assign wr_stream.data  = s_tdata;
	assign wr_stream.last  = s_tlast;

	always_comb begin
		cmd = '0;
		case (state)
			T_WRPTR: begin
				cmd.opcode   = `NIC_WCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_EUDAWRPTL;
				cmd.wr_count = 3'd2;  // Frame goes to SRAM 0000h
			end
			T_DATA: begin
				cmd.opcode = `NIC_WUDADATA;
				cmd.phase  = ph_stream_wr;
			end
			T_LEN: begin
				cmd.opcode   = `NIC_WCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_ETXSTL;
				cmd.wr_count = 3'd4;
				cmd.wr_word  = {pkt_len, 16'h0000};  // ETXST 0000h, then ETXLEN
			end
			T_RTS: cmd.opcode = `NIC_SETTXRTS;
			default: ;
		endcase
	end

	always_ff @(posedge AXIS_ACLK) begin
		if (!AXIS_ARESETN) begin
			state     <= T_IDLE;
			cmd_start <= 1'b0;
			s_tready  <= 1'b0;
		end else begin
			cmd_start <= 1'b0;
			s_tready  <= wr_take;  // Beat done once its byte is on the wire
			if (wr_take)
				pkt_len <= pkt_len + 16'd1;
			case (state)
				T_IDLE: begin
					if (start) begin
						state     <= T_WRPTR;
						cmd_start <= 1'b1;
						pkt_len   <= 16'd0;
					end
				end
				T_WRPTR: begin
					if (cmd_done) begin
						state     <= T_DATA;
						cmd_start <= 1'b1;
					end
				end
				T_DATA: begin
					if (cmd_done) begin
						state     <= T_LEN;
						cmd_start <= 1'b1;
					end
				end
				T_LEN: begin
					if (cmd_done) begin
						state     <= T_RTS;
						cmd_start <= 1'b1;
					end
				end
				T_RTS: begin
					if (cmd_done)
						state <= T_IDLE;
				end
				default: state <= T_IDLE;
			endcase
		end
	end

endmodule

/* hw/nic100_rx_seq.sv */
`timescale 1ns/1ps
`include "nic100_cfg.svh"

module nic100_rx_seq import nic100_pkg::*; (
	input  logic         AXIS_ACLK,
	input  logic         AXIS_ARESETN,
	input  logic         start,
	input  logic         cmd_done,
	input  logic [15:0]  rd_word,
	input  stream_byte_t rd_stream,
	output spi_cmd_t     cmd,
	output logic         cmd_start,
	output logic         rd_halt,
	output logic [7:0]   m_tdata,
	output logic         m_tvalid,
	output logic         m_tlast,
	output logic         busy
);

	// Next pointer and RSV length, then the skipped status bytes
	localparam int unsigned HDR_BYTES = 4 + `NIC_RSV_SKIP;

	typedef enum logic [2:0] {
		R_IDLE, R_PKTCNT, R_RDPT, R_DATA, R_TAIL, R_DEC
	} state_e;

	state_e      state;
	logic [15:0] next_ptr;
	logic [15:0] rsv_len;
	logic [15:0] byte_cnt;  // Bytes seen in the streamed read
	logic [15:0] last_cnt;
	logic        in_payload;
	logic        pay_last;

	assign last_cnt   = rsv_len + 16'(HDR_BYTES) - 16'(`NIC_CRC_BYTES) - 16'd1;
	assign in_payload = (state == R_DATA) && rd_stream.valid && (byte_cnt >= 16'(HDR_BYTES));
	assign pay_last   = in_payload && (byte_cnt == last_cnt);
	assign rd_halt    = pay_last;  // CRC stays in the buffer
	assign busy       = (state != R_IDLE);

	always_comb begin
		cmd = '0;
		case (state)
			R_PKTCNT: begin
				cmd.opcode   = `NIC_RCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_PKTCNT;
				cmd.rd_count = 2'd1;
			end
			R_RDPT: begin
				cmd.opcode   = `NIC_WRXRDPT;
				cmd.wr_count = 3'd2;
				cmd.wr_word  = {16'h0000, next_ptr};
			end
			R_DATA: begin
				cmd.opcode = `NIC_RRXDATA;
				cmd.phase  = ph_stream_rd;
			end
			R_TAIL: begin
				cmd.opcode   = `NIC_WCRU;
				cmd.has_addr = 1'b1;
				cmd.addr     = `NIC_ERXTAILL;
				cmd.wr_count = 3'd2;
				cmd.wr_word  = {16'h0000, next_ptr - 16'd2};
			end
			R_DEC: cmd.opcode = `NIC_SETPKTDEC;
			default: ;
		endcase
	end

	always_ff @(posedge AXIS_ACLK) begin
		if (!AXIS_ARESETN) begin
			state     <= R_IDLE;
			cmd_start <= 1'b0;
			next_ptr  <= `NIC_RX_START;
			m_tvalid  <= 1'b0;
			m_tlast   <= 1'b0;
		end else begin
			cmd_start <= 1'b0;
			m_tvalid  <= in_payload;
			m_tlast   <= pay_last;
			if (in_payload)
				m_tdata <= rd_stream.data;
			if (state == R_DATA && rd_stream.valid) begin
				byte_cnt <= byte_cnt + 16'd1;
				case (byte_cnt)
					16'd0: next_ptr[7:0]  <= rd_stream.data;
					16'd1: next_ptr[15:8] <= rd_stream.data;
					16'd2: rsv_len[7:0]   <= rd_stream.data;
					16'd3: rsv_len[15:8]  <= rd_stream.data;
					default: ;
				endcase
			end
			case (state)
				R_IDLE: begin
					if (start) begin
						state     <= R_PKTCNT;
						cmd_start <= 1'b1;
					end
				end
				R_PKTCNT: begin
					if (cmd_done) begin
						if (rd_word == 16'h0000) begin
							state <= R_IDLE;  // Nothing waiting
						end else begin
							state     <= R_RDPT;
							cmd_start <= 1'b1;
						end
					end
				end
				R_RDPT: begin
					if (cmd_done) begin
						state     <= R_DATA;
						cmd_start <= 1'b1;
						byte_cnt  <= 16'd0;
					end
				end
				R_DATA: begin
					if (cmd_done) begin
						state     <= R_TAIL;
						cmd_start <= 1'b1;
					end
				end
				R_TAIL: begin
					if (cmd_done) begin
						state     <= R_DEC;
						cmd_start <= 1'b1;
					end
				end
				R_DEC: begin
					if (cmd_done)
						state <= R_IDLE;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

endmodule

/* hw/nic100_axis_ctrl.sv */
`timescale 1ns/1ps

module nic100_axis_ctrl import nic100_pkg::*; (
	input  logic        AXIS_ACLK,
	input  logic        AXIS_ARESETN,
	input  logic [31:0] S_AXIS_TDATA,
	input  logic        S_AXIS_TLAST,
	input  logic        S_AXIS_TVALID,
	output logic        S_AXIS_TREADY,
	output logic [31:0] M_AXIS_TDATA,
	output logic        M_AXIS_TLAST,
	output logic        M_AXIS_TVALID,
	input  logic        M_AXIS_TREADY,
	output logic        wr_valid,
	output logic [7:0]  wr_data,
	input  logic        wr_got_byte,
	input  logic        wr_done,
	input  logic        rd_valid,
	output logic        rd_stop,
	input  logic [7:0]  rd_data
);

	typedef enum logic [1:0] {M_INIT, M_IDLE, M_TX, M_RX} mode_e;

	mode_e        mode;
	spi_cmd_t     init_cmd, tx_cmd, rx_cmd, exe_cmd;
	logic         init_cmd_start, tx_cmd_start, rx_cmd_start, exe_cmd_start;
	logic         init_done, tx_busy, rx_busy;
	logic         tx_go, rx_go;
	logic         cmd_done, wr_take, rd_halt;
	logic [15:0]  rd_word;
	logic [7:0]   m_tdata;
	stream_byte_t wr_stream, rd_stream;
	spi_wr_t      spi_wr;

	// Transmit wins when both sides want the bus
	assign tx_go = (mode == M_IDLE) && S_AXIS_TVALID;
	assign rx_go = (mode == M_IDLE) && !S_AXIS_TVALID && M_AXIS_TREADY;

	always_ff @(posedge AXIS_ACLK) begin
		if (!AXIS_ARESETN) begin
			mode <= M_INIT;
		end else begin
			case (mode)
				M_INIT: if (init_done) mode <= M_IDLE;
				M_IDLE: begin
					if (tx_go)
						mode <= M_TX;
					else if (rx_go)
						mode <= M_RX;
				end
				M_TX: if (!tx_busy) mode <= M_IDLE;
				M_RX: if (!rx_busy) mode <= M_IDLE;
				default: mode <= M_INIT;
			endcase
		end
	end

	// Only the active sequencer reaches the executor
	always_comb begin
		case (mode)
			M_TX: begin
				exe_cmd       = tx_cmd;
				exe_cmd_start = tx_cmd_start;
			end
			M_RX: begin
				exe_cmd       = rx_cmd;
				exe_cmd_start = rx_cmd_start;
			end
			M_INIT: begin
				exe_cmd       = init_cmd;
				exe_cmd_start = init_cmd_start;
			end
			default: begin
				exe_cmd       = init_cmd;
				exe_cmd_start = 1'b0;
			end
		endcase
	end

	assign wr_valid     = spi_wr.wr_valid;
	assign wr_data      = spi_wr.wr_data;
	assign M_AXIS_TDATA = {24'h000000, m_tdata};

	nic100_spi_cmd cmd_i (
		.AXIS_ACLK    (AXIS_ACLK),
		.AXIS_ARESETN (AXIS_ARESETN),
		.cmd          (exe_cmd),
		.cmd_start    (exe_cmd_start),
		.wr_stream    (wr_stream),
		.rd_halt      (rd_halt),
		.wr_got_byte  (wr_got_byte),
		.wr_done      (wr_done),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.spi_wr       (spi_wr),
		.rd_stop      (rd_stop),
		.cmd_done     (cmd_done),
		.rd_word      (rd_word),
		.wr_take      (wr_take),
		.rd_stream    (rd_stream)
	);

	nic100_init_seq init_i (
		.AXIS_ACLK    (AXIS_ACLK),
		.AXIS_ARESETN (AXIS_ARESETN),
		.cmd_done     (cmd_done),
		.rd_word      (rd_word),
		.cmd          (init_cmd),
		.cmd_start    (init_cmd_start),
		.init_done    (init_done)
	);

	nic100_tx_seq tx_i (
		.AXIS_ACLK    (AXIS_ACLK),
		.AXIS_ARESETN (AXIS_ARESETN),
		.start        (tx_go),
		.cmd_done     (cmd_done),
		.s_tdata      (S_AXIS_TDATA[7:0]),  // One byte per beat
		.s_tvalid     (S_AXIS_TVALID),
		.s_tlast      (S_AXIS_TLAST),
		.wr_take      (wr_take),
		.cmd          (tx_cmd),
		.cmd_start    (tx_cmd_start),
		.wr_stream    (wr_stream),
		.s_tready     (S_AXIS_TREADY),
		.busy         (tx_busy)
	);

	nic100_rx_seq rx_i (
		.AXIS_ACLK    (AXIS_ACLK),
		.AXIS_ARESETN (AXIS_ARESETN),
		.start        (rx_go),
		.cmd_done     (cmd_done),
		.rd_word      (rd_word),
		.rd_stream    (rd_stream),
		.cmd          (rx_cmd),
		.cmd_start    (rx_cmd_start),
		.rd_halt      (rd_halt),
		.m_tdata      (m_tdata),
		.m_tvalid     (M_AXIS_TVALID),
		.m_tlast      (M_AXIS_TLAST),
		.busy         (rx_busy)
	);

endmodule

/* verification/nic100_properties.sv */
`timescale 1ns/1ps

module nic100_properties (
	input logic AXIS_ACLK,
	input logic AXIS_ARESETN,
	input logic wr_valid,
	input logic rd_stop,
	input logic S_AXIS_TREADY,
	input logic M_AXIS_TVALID,
	input logic M_AXIS_TLAST
);

	// Read and write sides never overlap
	ap_rd_excl: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
		!rd_stop |-> !wr_valid) else $error("wr_valid high while rd_stop low");

	ap_tlast: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
		M_AXIS_TLAST |-> M_AXIS_TVALID) else $error("M_AXIS_TLAST without M_AXIS_TVALID");

	ap_tready_pulse: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
		S_AXIS_TREADY |=> !S_AXIS_TREADY) else $error("S_AXIS_TREADY longer than one cycle");

	ap_tvalid_pulse: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
		M_AXIS_TVALID |=> !M_AXIS_TVALID) else $error("M_AXIS_TVALID longer than one cycle");

	// Outputs idle at the first edge out of reset
	ap_reset_idle: assert property (@(posedge AXIS_ACLK) $rose(AXIS_ARESETN) |->
		(!wr_valid && !S_AXIS_TREADY && !M_AXIS_TVALID && !M_AXIS_TLAST && rd_stop))
		else $error("control outputs active after reset");

endmodule

bind nic100_axis_ctrl nic100_properties props_i (
	.AXIS_ACLK     (AXIS_ACLK),
	.AXIS_ARESETN  (AXIS_ARESETN),
	.wr_valid      (wr_valid),
	.rd_stop       (rd_stop),
	.S_AXIS_TREADY (S_AXIS_TREADY),
	.M_AXIS_TVALID (M_AXIS_TVALID),
	.M_AXIS_TLAST  (M_AXIS_TLAST)
);

/* verification/nic100_tb.sv */
`timescale 1ns/1ps
`include "nic100_cfg.svh"

module nic100_tb;

	logic        AXIS_ACLK = 1'b0;
	logic        AXIS_ARESETN;
	logic [31:0] S_AXIS_TDATA, M_AXIS_TDATA;
	logic        S_AXIS_TLAST, S_AXIS_TVALID, S_AXIS_TREADY;
	logic        M_AXIS_TLAST, M_AXIS_TVALID, M_AXIS_TREADY;
	logic        wr_valid, wr_got_byte, wr_done, rd_valid, rd_stop;
	logic [7:0]  wr_data, rd_data;

	logic [31:0] lfsr;
	logic [7:0]  log_bytes[$], exp_log[$], exp_out[$], tx_bytes[$], exp_b;
	logic [7:0]  rxmem [0:65535];
	logic [7:0]  eudast [0:1];
	logic [15:0] rx_ptr, ptr, next;
	int          errors = 0, ntests = 0, cmd_count = 0, exp_cmds = 0, out_count = 0;
	int          eudast_bad = 1, clk_polls = 3, pktcnt = 0, pktcnt_reads = 0;
	int          rrx_count = 0, rts_count = 0, rd_idx, err0, base, rrx_base, t, n;

	nic100_axis_ctrl dut_i (.*);

	always #50 AXIS_ACLK = ~AXIS_ACLK;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int nb);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < nb; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// Expected written bytes of one command
	function automatic void ref_cmd(input logic [7:0] op, input bit has_addr,
			input logic [7:0] addr, input int nb, input logic [31:0] word);
		exp_log.push_back(op);
		if (has_addr)
			exp_log.push_back(addr);
		for (int i = 0; i < nb; i++)
			exp_log.push_back(word[8*i +: 8]);
		exp_cmds++;
	endfunction

	function automatic logic [7:0] read_byte(input logic [7:0] op, input logic [7:0] addr);
		if (op == `NIC_RRXDATA) begin
			rx_ptr++;
			return rxmem[rx_ptr - 16'd1];
		end
		if (addr == `NIC_EUDASTL)
			return (eudast_bad > 0) ? 8'hEE : eudast[rd_idx];
		if (addr == `NIC_ESTATH)
			return (clk_polls > 0) ? 8'h00 : `NIC_CLKRDY;
		if (addr == `NIC_PKTCNT)
			return (rd_idx == 0) ? 8'(pktcnt) : 8'h00;
		return 8'h00;
	endfunction

	// SPI controller model
	initial begin : spi_model
		logic [7:0] cur[$];
		wr_got_byte = 1'b0;
		wr_done     = 1'b0;
		rd_valid    = 1'b0;
		rd_data     = 8'h00;
		forever begin
			@(posedge AXIS_ACLK);
			#1;
			if (AXIS_ARESETN && wr_valid) begin
				cur.delete();
				while (wr_valid && cur.size() < 64) begin
					repeat (3) @(posedge AXIS_ACLK);
					#1 wr_got_byte = 1'b1;
					cur.push_back(wr_data);
					log_bytes.push_back(wr_data);
					@(posedge AXIS_ACLK);
					#1 wr_got_byte = 1'b0;
				end
				assert (!wr_valid) else begin
					errors++;
					$display("wr_valid still high after %0d bytes", cur.size());
				end
				rd_idx = 0;
				if (!rd_stop) begin
					while (!rd_stop && rd_idx < 256) begin
						repeat (2) @(posedge AXIS_ACLK);
						#1 rd_data = read_byte(cur[0], (cur.size() > 1) ? cur[1] : 8'h00);
						rd_valid = 1'b1;
						rd_idx++;
						@(posedge AXIS_ACLK);
						#1 rd_valid = 1'b0;
					end
					assert (rd_stop) else begin
						errors++;
						$display("rd_stop still low after %0d bytes", rd_idx);
					end
				end else begin
					repeat (2) @(posedge AXIS_ACLK);
					#1 wr_done = 1'b1;
					@(posedge AXIS_ACLK);
					#1 wr_done = 1'b0;
				end
				// Register side effects
				if (cur[0] == `NIC_RCRU && cur[1] == `NIC_EUDASTL && eudast_bad > 0)
					eudast_bad--;
				if (cur[0] == `NIC_RCRU && cur[1] == `NIC_ESTATH && clk_polls > 0)
					clk_polls--;
				if (cur[0] == `NIC_RCRU && cur[1] == `NIC_PKTCNT)
					pktcnt_reads++;
				if (cur[0] == `NIC_WCRU && cur[1] == `NIC_EUDASTL) begin
					eudast[0] = cur[2];
					eudast[1] = cur[3];
				end
				if (cur[0] == `NIC_WRXRDPT)
					rx_ptr = {cur[2], cur[1]};
				if (cur[0] == `NIC_RRXDATA)
					rrx_count++;
				if (cur[0] == `NIC_SETPKTDEC && pktcnt > 0)
					pktcnt--;
				if (cur[0] == `NIC_SETTXRTS)
					rts_count++;
				cmd_count++;
			end
		end
	end

	// Master-stream compare process
	always @(posedge AXIS_ACLK) begin
		if (AXIS_ARESETN && M_AXIS_TVALID) begin
			out_count++;
			if (exp_out.size() == 0) begin
				errors++;
				$display("unexpected byte on the master stream");
			end else begin
				exp_b = exp_out.pop_front();
				assert (M_AXIS_TDATA == {24'h000000, exp_b}) else begin
					errors++;
					$display("ERROR M_AXIS_TDATA got %h exp %h", M_AXIS_TDATA, exp_b);
				end
				assert (M_AXIS_TLAST == (exp_out.size() == 0)) else begin
					errors++;
					$display("ERROR M_AXIS_TLAST got %h exp %h", M_AXIS_TLAST,
						exp_out.size() == 0);
				end
			end
		end
	end

	task automatic wait_cmds(input int target);
		t = 0;
		while (cmd_count < target && t < 20000) begin
			@(posedge AXIS_ACLK);
			t++;
		end
		assert (cmd_count >= target) else begin
			errors++;
			$display("timed out waiting for SPI command %0d", target);
		end
		repeat (4) @(posedge AXIS_ACLK);  // Mode back to idle
		#1;
	endtask

	task automatic check_log();
		assert (log_bytes.size() == exp_log.size()) else begin
			errors++;
			$display("ERROR log length got %h exp %h", log_bytes.size(), exp_log.size());
		end
		for (int i = 0; i < log_bytes.size() && i < exp_log.size(); i++)
			assert (log_bytes[i] == exp_log[i]) else begin
				errors++;
				$display("ERROR wr_data byte %0d got %h exp %h", i, log_bytes[i], exp_log[i]);
			end
		log_bytes.delete();
		exp_log.delete();
	endtask

	task automatic end_test(input string name);
		ntests++;
		$display("%s: %s", name, (errors == err0) ? "ok" : "FAILED");
		err0 = errors;
	endtask

	task automatic send_packet();
		S_AXIS_TVALID = 1'b1;
		for (int i = 0; i < tx_bytes.size(); i++) begin
			S_AXIS_TDATA = {24'(rand_bits(24)), tx_bytes[i]};  // Upper bytes unused
			S_AXIS_TLAST = (i == tx_bytes.size() - 1);
			t = 0;
			do begin
				@(posedge AXIS_ACLK);
				#1 t++;
			end while (!S_AXIS_TREADY && t < 5000);
			assert (S_AXIS_TREADY) else begin
				errors++;
				$display("timed out waiting for S_AXIS_TREADY on beat %0d", i);
			end
		end
		S_AXIS_TVALID = 1'b0;
		S_AXIS_TLAST  = 1'b0;
	endtask

	// Frame in receive memory plus its expected commands and payload
	task automatic load_frame(input logic [15:0] at, input logic [15:0] nxt, input int np);
		rxmem[at]     = nxt[7:0];
		rxmem[at + 1] = nxt[15:8];
		rxmem[at + 2] = 8'(np + `NIC_CRC_BYTES);
		rxmem[at + 3] = 8'h00;
		for (int i = 0; i < `NIC_RSV_SKIP + np + `NIC_CRC_BYTES; i++)
			rxmem[at + 4 + i] = 8'(rand_bits(8));
		for (int i = 0; i < np; i++)
			exp_out.push_back(rxmem[at + 4 + `NIC_RSV_SKIP + i]);
		ref_cmd(`NIC_RCRU, 1, `NIC_PKTCNT, 0, 0);
		ref_cmd(`NIC_WRXRDPT, 0, 0, 2, {16'h0000, at});
		ref_cmd(`NIC_RRXDATA, 0, 0, 0, 0);
		ref_cmd(`NIC_WCRU, 1, `NIC_ERXTAILL, 2, {16'h0000, nxt - 16'd2});
		ref_cmd(`NIC_SETPKTDEC, 0, 0, 0, 0);
	endtask

	initial begin : watchdog
		#20_000_000;
		$display("watchdog expired, simulation stuck");
		$display("sim failed");
		$finish;
	end

	initial begin
		lfsr          = 32'h222cf867;
		AXIS_ARESETN  = 1'b0;
		S_AXIS_TDATA  = '0;
		S_AXIS_TLAST  = 1'b0;
		S_AXIS_TVALID = 1'b0;
		M_AXIS_TREADY = 1'b0;
		err0          = 0;
		for (int i = 0; i <= 8; i++) begin
			@(posedge AXIS_ACLK);
			#1;
			if (i == 8)
				AXIS_ARESETN = 1'b1;
			assert (!wr_valid && !S_AXIS_TREADY && !M_AXIS_TVALID && !M_AXIS_TLAST && rd_stop)
				else begin
				errors++;
				$display("control outputs active in reset, cycle %0d", i);
			end
		end
		end_test("reset state");

		// Bring-up: one failed readback, three clear CLKRDY polls
		for (int r = 0; r < 2; r++) begin
			ref_cmd(`NIC_WCRU, 1, `NIC_EUDASTL, 2, {16'h0000, `NIC_EUDAST_PATTERN});
			ref_cmd(`NIC_RCRU, 1, `NIC_EUDASTL, 0, 0);
		end
		repeat (4) ref_cmd(`NIC_RCRU, 1, `NIC_ESTATH, 0, 0);
		ref_cmd(`NIC_WCRU, 1, `NIC_ERXSTL, 4, {`NIC_RX_TAIL_INIT, `NIC_RX_START});
		ref_cmd(`NIC_BFSU, 1, `NIC_ECON1L, 1, {24'h000000, `NIC_RXEN});
		wait_cmds(exp_cmds);
		check_log();
		end_test("bring-up");

		// Transmit
		n = 1 + rand_bits(5) % 20;
		for (int i = 0; i < n; i++)
			tx_bytes.push_back(8'(rand_bits(8)));
		ref_cmd(`NIC_WCRU, 1, `NIC_EUDAWRPTL, 2, 0);
		ref_cmd(`NIC_WUDADATA, 0, 0, 0, 0);
		foreach (tx_bytes[i])
			exp_log.push_back(tx_bytes[i]);
		ref_cmd(`NIC_WCRU, 1, `NIC_ETXSTL, 4, {16'(n), 16'h0000});
		ref_cmd(`NIC_SETTXRTS, 0, 0, 0, 0);
		send_packet();
		wait_cmds(exp_cmds);
		check_log();
		end_test("transmit");

		// Two frames, the second at the first one's next pointer
		ptr = `NIC_RX_START;
		for (int f = 0; f < 2; f++) begin
			next   = ptr + 16'h0100 + 16'(rand_bits(6));
			pktcnt = 1;
			load_frame(ptr, next, 1 + rand_bits(4) % 16);
			M_AXIS_TREADY = 1'b1;
			@(posedge AXIS_ACLK);
			#1 M_AXIS_TREADY = 1'b0;
			wait_cmds(exp_cmds);
			assert (exp_out.size() == 0) else begin
				errors++;
				$display("master stream ended with %0d bytes missing", exp_out.size());
			end
			ptr = next;
		end
		check_log();
		end_test("receive");

		// Empty buffer keeps polling, transmit still served
		base     = out_count;
		n        = pktcnt_reads;
		rrx_base = rrx_count;
		M_AXIS_TREADY = 1'b1;
		for (int w = 0; w < 20000 && pktcnt_reads < n + 3; w++)
			@(posedge AXIS_ACLK);
		assert (pktcnt_reads >= n + 3) else begin
			errors++;
			$display("PKTCNT is not polled repeatedly");
		end
		#1;
		tx_bytes.delete();
		tx_bytes.push_back(8'(rand_bits(8)));
		n = rts_count;
		send_packet();
		for (int w = 0; w < 20000 && rts_count == n; w++)
			@(posedge AXIS_ACLK);
		assert (rts_count > n) else begin
			errors++;
			$display("transmit not served while the receive side polls");
		end
		#1 M_AXIS_TREADY = 1'b0;
		assert (rrx_count == rrx_base && out_count == base) else begin
			errors++;
			$display("data read from an empty receive buffer");
		end
		end_test("empty receive buffer");

		$display("%0d tests, %0d errors", ntests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+common
common/nic100_pkg.sv
hw/nic100_spi_cmd.sv
hw/nic100_init_seq.sv
hw/nic100_tx_seq.sv
hw/nic100_rx_seq.sv
hw/nic100_axis_ctrl.sv
verification/nic100_properties.sv
verification/nic100_tb.sv
